/* design/gat_pkg.sv */
// Fixed 16-in/4-out layer with 8-bit signed data; WH and score widths hold worst-case sums
package gat_pkg;

  // ==============================
  // Widths and sizes
  // ==============================
  localparam int DATA_WIDTH    = 8;
  localparam int FEAT_IN       = 16;
  localparam int FEAT_OUT      = 4;
  localparam int COL_IDX_WIDTH = 4;
  localparam int ROW_LEN_WIDTH = 5;
  localparam int WH_WIDTH      = 20;
  localparam int SCORE_WIDTH   = 30;

  // W row-major by input feature, then a[0..FEAT_OUT-1]
  localparam int WGT_DEPTH     = FEAT_IN * FEAT_OUT + FEAT_OUT;

  // ==============================
  // Payload types
  // ==============================
  // One nonzero of sparse H
  typedef struct packed {
    logic signed [DATA_WIDTH-1:0]    value;
    logic        [COL_IDX_WIDTH-1:0] col;
  } h_entry_t;

  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0] row_len;
  } node_info_t;

  // Lanes are two's complement, read them through $signed
  typedef logic [FEAT_OUT-1:0][WH_WIDTH-1:0] wh_row_t;

  typedef struct packed {
    wh_row_t                        wh;
    logic signed [SCORE_WIDTH-1:0]  score;
  } feat_word_t;

  typedef logic [FEAT_IN-1:0][FEAT_OUT-1:0][DATA_WIDTH-1:0] weight_mat_t;

  typedef logic [FEAT_OUT-1:0][DATA_WIDTH-1:0] att_vec_t;

endpackage

/* design/gat_bram.sv */
// Read data appears one cycle after the address; reading a word being written returns old data
module gat_bram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
  input  payload_t                 wr_data_i,
  input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
  output payload_t                 rd_data_o
);

  payload_t mem [DEPTH];
  payload_t rd_data_q;

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    rd_data_q <= mem[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

/* design/weight_scheduler.sv */
// Loads W and a once per reset; later weight memory writes are not picked up
module weight_scheduler (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start_i,
  output logic [$clog2(gat_pkg::WGT_DEPTH)-1:0] wgt_addr_o,
  input  logic [gat_pkg::DATA_WIDTH-1:0]        wgt_data_i,
  output gat_pkg::weight_mat_t                  w_o,
  output gat_pkg::att_vec_t                     a_o,
  output logic                                  sched_rdy_o
);

  import gat_pkg::*;

  localparam int ADDR_W  = $clog2(WGT_DEPTH);
  localparam int W_WORDS = FEAT_IN * FEAT_OUT;

  logic              started_q;
  logic              busy_q;
  logic [ADDR_W-1:0] addr_q;
  logic              rd_vld_q;
  logic [ADDR_W-1:0] rd_idx_q;
  logic              rdy_q;
  weight_mat_t       w_q;
  att_vec_t          a_q;

  // ==============================
  // Address sweep
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started_q <= 1'b0;
      busy_q    <= 1'b0;
      addr_q    <= '0;
      rd_vld_q  <= 1'b0;
      rd_idx_q  <= '0;
      rdy_q     <= 1'b0;
    end else begin
      // Word addressed this cycle returns next cycle
      rd_vld_q <= busy_q;
      rd_idx_q <= addr_q;
      if (start_i && !started_q) begin
        started_q <= 1'b1;
        busy_q    <= 1'b1;
        addr_q    <= '0;
      end else if (busy_q) begin
        if (addr_q == ADDR_W'(WGT_DEPTH - 1)) begin
          busy_q <= 1'b0;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
      if (rd_vld_q && rd_idx_q == ADDR_W'(WGT_DEPTH - 1)) begin
        rdy_q <= 1'b1;
      end
    end
  end

  // ==============================
  // Unpack into W and a
  // ==============================
  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      if (rd_idx_q < ADDR_W'(W_WORDS)) begin
        w_q[rd_idx_q / FEAT_OUT][rd_idx_q % FEAT_OUT] <= wgt_data_i;
      end else begin
        a_q[rd_idx_q - ADDR_W'(W_WORDS)] <= wgt_data_i;
      end
    end
  end

  assign wgt_addr_o  = addr_q;
  assign w_o         = w_q;
  assign a_o         = a_q;
  assign sched_rdy_o = rdy_q;

endmodule

/* design/sparse_wh_engine.sv */
// Runs once per reset over nodes 0..NUM_NODES-1; rows are packed back to back in H from word 0
module sparse_wh_engine #(
  parameter int NUM_NODES = 16,
  parameter int H_DEPTH   = 128
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start_i,
  input  gat_pkg::weight_mat_t         w_i,
  output logic [$clog2(NUM_NODES)-1:0] info_addr_o,
  input  gat_pkg::node_info_t          info_i,
  output logic [$clog2(H_DEPTH)-1:0]   h_addr_o,
  input  gat_pkg::h_entry_t            h_i,
  output logic                         wh_vld_o,
  output gat_pkg::wh_row_t             wh_o,
  output logic [$clog2(NUM_NODES)-1:0] node_o,
  output logic                         last_o
);

  import gat_pkg::*;

  localparam int NODE_W = $clog2(NUM_NODES);
  localparam int H_AW   = $clog2(H_DEPTH);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_ACCUM,
    S_EMIT
  } state_t;

  state_t                         state_q;
  logic [NODE_W-1:0]              node_q;
  logic [H_AW-1:0]                h_ptr_q;
  logic [ROW_LEN_WIDTH-1:0]       remain_q;
  logic                           h_vld_q;
  logic                           finished_q;
  logic                           is_last;
  wh_row_t                        acc_q;
  logic signed [2*DATA_WIDTH-1:0] prod [FEAT_OUT];

  assign is_last = (node_q == NODE_W'(NUM_NODES - 1));

  // ==============================
  // Node walk FSM
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= S_IDLE;
      node_q     <= '0;
      h_ptr_q    <= '0;
      remain_q   <= '0;
      h_vld_q    <= 1'b0;
      finished_q <= 1'b0;
    end else begin
      // An H read issued now has data next cycle
      h_vld_q <= (state_q == S_ACCUM) && (remain_q != '0);
      case (state_q)
        S_IDLE: begin
          if (start_i && !finished_q) begin
            state_q <= S_FETCH;
          end
        end
        S_FETCH: begin
          remain_q <= info_i.row_len;
          state_q  <= (info_i.row_len == '0) ? S_EMIT : S_ACCUM;
        end
        S_ACCUM: begin
          if (remain_q != '0) begin
            h_ptr_q  <= h_ptr_q + 1'b1;
            remain_q <= remain_q - 1'b1;
          end else begin
            // Last entry is added on this same edge
            state_q <= S_EMIT;
          end
        end
        S_EMIT: begin
          node_q <= node_q + 1'b1;
          if (is_last) begin
            state_q    <= S_IDLE;
            finished_q <= 1'b1;
          end else begin
            state_q <= S_FETCH;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Look ahead one node during emit so row_len is ready in fetch
  assign info_addr_o = (state_q == S_EMIT) ? node_q + 1'b1 : node_q;
  assign h_addr_o    = h_ptr_q;

  // ==============================
  // Lane accumulators
  // ==============================
  always_comb begin
    for (int o = 0; o < FEAT_OUT; o++) begin
      prod[o] = h_i.value * $signed(w_i[h_i.col][o]);
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE || state_q == S_EMIT) begin
      acc_q <= '0;
    end else if (h_vld_q) begin
      for (int o = 0; o < FEAT_OUT; o++) begin
        acc_q[o] <= $signed(acc_q[o]) + prod[o];
      end
    end
  end

  assign wh_vld_o = (state_q == S_EMIT);
  assign wh_o     = acc_q;
  assign node_o   = node_q;
  assign last_o   = wh_vld_o && is_last;

endmodule

/* design/attention_score.sv */
// Score is the exact signed dot product, no rounding or saturation; accepts one row per cycle
module attention_score #(
  parameter int NUM_NODES = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  gat_pkg::att_vec_t            a_i,
  input  logic                         wh_vld_i,
  input  gat_pkg::wh_row_t             wh_i,
  input  logic [$clog2(NUM_NODES)-1:0] node_i,
  input  logic                         last_i,
  output logic                         feat_we_o,
  output logic [$clog2(NUM_NODES)-1:0] feat_addr_o,
  output gat_pkg::feat_word_t          feat_data_o,
  output logic                         done_o
);

  import gat_pkg::*;

  localparam int NODE_W = $clog2(NUM_NODES);
  localparam int PROD_W = DATA_WIDTH + WH_WIDTH;

  logic                          s1_vld_q;
  logic                          s1_last_q;
  wh_row_t                       s1_wh_q;
  logic [NODE_W-1:0]             s1_node_q;
  logic signed [PROD_W-1:0]      s1_prod_q [FEAT_OUT];
  logic signed [SCORE_WIDTH-1:0] score_sum;
  logic                          s2_last_q;
  logic                          done_q;

  struct packed {
    logic              en;
    logic [NODE_W-1:0] addr;
    feat_word_t        data;
  } feat_wr_q;

  // ==============================
  // Stage 1: lane products
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q  <= 1'b0;
      s1_last_q <= 1'b0;
    end else begin
      s1_vld_q  <= wh_vld_i;
      s1_last_q <= wh_vld_i && last_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_wh_q   <= wh_i;
    s1_node_q <= node_i;
    for (int o = 0; o < FEAT_OUT; o++) begin
      s1_prod_q[o] <= $signed(a_i[o]) * $signed(wh_i[o]);
    end
  end

  // ==============================
  // Stage 2: sum and write
  // ==============================
  always_comb begin
    score_sum = '0;
    for (int o = 0; o < FEAT_OUT; o++) begin
      score_sum = score_sum + s1_prod_q[o];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      feat_wr_q <= '0;
      s2_last_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      feat_wr_q.en         <= s1_vld_q;
      feat_wr_q.addr       <= s1_node_q;
      feat_wr_q.data.wh    <= s1_wh_q;
      feat_wr_q.data.score <= score_sum;
      s2_last_q            <= s1_last_q;
      // Sticky until reset
      if (feat_wr_q.en && s2_last_q) begin
        done_q <= 1'b1;
      end
    end
  end

  assign feat_we_o   = feat_wr_q.en;
  assign feat_addr_o = feat_wr_q.addr;
  assign feat_data_o = feat_wr_q.data;
  assign done_o      = done_q;

endmodule

/* design/gat_core.sv */
// Single-pass layer 1 core; host must not write memories while compute runs
module gat_core #(
  parameter int NUM_NODES = 16,
  parameter int H_DEPTH   = 128
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  h_we_i,
  input  logic [$clog2(H_DEPTH)-1:0]            h_addr_i,
  input  gat_pkg::h_entry_t                     h_data_i,
  input  logic                                  info_we_i,
  input  logic [$clog2(NUM_NODES)-1:0]          info_addr_i,
  input  gat_pkg::node_info_t                   info_data_i,
  input  logic                                  wgt_we_i,
  input  logic [$clog2(gat_pkg::WGT_DEPTH)-1:0] wgt_addr_i,
  input  logic [gat_pkg::DATA_WIDTH-1:0]        wgt_data_i,
  input  logic                                  h_load_done_i,
  input  logic                                  info_load_done_i,
  input  logic                                  wgt_load_done_i,
  input  logic [$clog2(NUM_NODES)-1:0]          feat_addr_i,
  output gat_pkg::feat_word_t                   feat_dout_o,
  output logic                                  done_o
);

  import gat_pkg::*;

  localparam int NODE_W = $clog2(NUM_NODES);
  localparam int H_AW   = $clog2(H_DEPTH);
  localparam int WGT_AW = $clog2(WGT_DEPTH);

  // ==============================
  // Memory write ports
  // ==============================
  struct packed {
    logic            en;
    logic [H_AW-1:0] addr;
    h_entry_t        data;
  } h_wr;

  struct packed {
    logic              en;
    logic [NODE_W-1:0] addr;
    node_info_t        data;
  } info_wr;

  struct packed {
    logic                  en;
    logic [WGT_AW-1:0]     addr;
    logic [DATA_WIDTH-1:0] data;
  } wgt_wr;

  struct packed {
    logic              en;
    logic [NODE_W-1:0] addr;
    feat_word_t        data;
  } feat_wr;

  assign h_wr    = {h_we_i, h_addr_i, h_data_i};
  assign info_wr = {info_we_i, info_addr_i, info_data_i};
  assign wgt_wr  = {wgt_we_i, wgt_addr_i, wgt_data_i};

  logic [H_AW-1:0]       h_rd_addr;
  h_entry_t              h_rd_data;
  logic [NODE_W-1:0]     info_rd_addr;
  node_info_t            info_rd_data;
  logic [WGT_AW-1:0]     wgt_rd_addr;
  logic [DATA_WIDTH-1:0] wgt_rd_data;
  weight_mat_t           w;
  att_vec_t              a;
  logic                  sched_rdy;
  logic                  start;
  logic                  wh_vld;
  wh_row_t               wh;
  logic [NODE_W-1:0]     wh_node;
  logic                  wh_last;

  // Compute starts only with weights unpacked and both H memories loaded
  assign start = sched_rdy && h_load_done_i && info_load_done_i;

  // ==============================
  // Memories
  // ==============================
  gat_bram #(.payload_t(h_entry_t), .DEPTH(H_DEPTH)) u_h_bram (
    .clk       (clk),
    .wr_en_i   (h_wr.en),
    .wr_addr_i (h_wr.addr),
    .wr_data_i (h_wr.data),
    .rd_addr_i (h_rd_addr),
    .rd_data_o (h_rd_data)
  );

  gat_bram #(.payload_t(node_info_t), .DEPTH(NUM_NODES)) u_info_bram (
    .clk       (clk),
    .wr_en_i   (info_wr.en),
    .wr_addr_i (info_wr.addr),
    .wr_data_i (info_wr.data),
    .rd_addr_i (info_rd_addr),
    .rd_data_o (info_rd_data)
  );

  gat_bram #(.payload_t(logic [DATA_WIDTH-1:0]), .DEPTH(WGT_DEPTH)) u_wgt_bram (
    .clk       (clk),
    .wr_en_i   (wgt_wr.en),
    .wr_addr_i (wgt_wr.addr),
    .wr_data_i (wgt_wr.data),
    .rd_addr_i (wgt_rd_addr),
    .rd_data_o (wgt_rd_data)
  );

  gat_bram #(.payload_t(feat_word_t), .DEPTH(NUM_NODES)) u_feat_bram (
    .clk       (clk),
    .wr_en_i   (feat_wr.en),
    .wr_addr_i (feat_wr.addr),
    .wr_data_i (feat_wr.data),
    .rd_addr_i (feat_addr_i),
    .rd_data_o (feat_dout_o)
  );

  // ==============================
  // Datapath
  // ==============================
  weight_scheduler u_weight_scheduler (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (wgt_load_done_i),
    .wgt_addr_o  (wgt_rd_addr),
    .wgt_data_i  (wgt_rd_data),
    .w_o         (w),
    .a_o         (a),
    .sched_rdy_o (sched_rdy)
  );

  sparse_wh_engine #(.NUM_NODES(NUM_NODES), .H_DEPTH(H_DEPTH)) u_sparse_wh_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .w_i         (w),
    .info_addr_o (info_rd_addr),
    .info_i      (info_rd_data),
    .h_addr_o    (h_rd_addr),
    .h_i         (h_rd_data),
    .wh_vld_o    (wh_vld),
    .wh_o        (wh),
    .node_o      (wh_node),
    .last_o      (wh_last)
  );

  attention_score #(.NUM_NODES(NUM_NODES)) u_attention_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .a_i         (a),
    .wh_vld_i    (wh_vld),
    .wh_i        (wh),
    .node_i      (wh_node),
    .last_i      (wh_last),
    .feat_we_o   (feat_wr.en),
    .feat_addr_o (feat_wr.addr),
    .feat_data_o (feat_wr.data),
    .done_o      (done_o)
  );

endmodule

/* tb/tb_gat_core.sv */
// Directed tests for gat_core at 16 nodes and 128 H words; each test starts from reset
module tb_gat_core;

  import gat_pkg::*;

  localparam int NUM_NODES  = 16;
  localparam int H_DEPTH    = 128;
  localparam int NODE_W     = $clog2(NUM_NODES);
  localparam int H_AW       = $clog2(H_DEPTH);
  localparam int WGT_AW     = $clog2(WGT_DEPTH);
  localparam int PERIOD     = 100;
  localparam int DRIVE_DLY  = 10;
  // Six tests, each under about 1500 cycles of load, compute and readback, with wide margin
  localparam int MAX_CYCLES = 20000;
  // Weight sweep about 70 cycles plus at most 19 cycles per node
  localparam int DONE_WAIT  = 1000;

  localparam int GRAPH_IDENTITY = 0;
  localparam int GRAPH_RANDOM   = 1;
  localparam int GRAPH_ZEROS    = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  h_we_i;
  logic [H_AW-1:0]       h_addr_i;
  h_entry_t              h_data_i;
  logic                  info_we_i;
  logic [NODE_W-1:0]     info_addr_i;
  node_info_t            info_data_i;
  logic                  wgt_we_i;
  logic [WGT_AW-1:0]     wgt_addr_i;
  logic [DATA_WIDTH-1:0] wgt_data_i;
  logic                  h_load_done_i;
  logic                  info_load_done_i;
  logic                  wgt_load_done_i;
  logic [NODE_W-1:0]     feat_addr_i;
  feat_word_t            feat_dout_o;
  logic                  done_o;

  // ==============================
  // Reference model state
  // ==============================
  byte                      h_val [H_DEPTH];
  logic [COL_IDX_WIDTH-1:0] h_col [H_DEPTH];
  int                       h_used;
  int                       row_len [NUM_NODES];
  byte                      w_mat [FEAT_IN][FEAT_OUT];
  byte                      a_vec [FEAT_OUT];
  int                       exp_wh [NUM_NODES][FEAT_OUT];
  int                       exp_score [NUM_NODES];

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycle_cnt;

  gat_core #(.NUM_NODES(NUM_NODES), .H_DEPTH(H_DEPTH)) UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .h_we_i           (h_we_i),
    .h_addr_i         (h_addr_i),
    .h_data_i         (h_data_i),
    .info_we_i        (info_we_i),
    .info_addr_i      (info_addr_i),
    .info_data_i      (info_data_i),
    .wgt_we_i         (wgt_we_i),
    .wgt_addr_i       (wgt_addr_i),
    .wgt_data_i       (wgt_data_i),
    .h_load_done_i    (h_load_done_i),
    .info_load_done_i (info_load_done_i),
    .wgt_load_done_i  (wgt_load_done_i),
    .feat_addr_i      (feat_addr_i),
    .feat_dout_o      (feat_dout_o),
    .done_o           (done_o)
  );

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic feat_word_t expected_word(input int n);
    feat_word_t word;
    int         o;
    for (o = 0; o < FEAT_OUT; o++) begin
      word.wh[o] = WH_WIDTH'(exp_wh[n][o]);
    end
    word.score = SCORE_WIDTH'(exp_score[n]);
    return word;
  endfunction

  // ==============================
  // Stimulus helpers
  // ==============================
  task automatic idle_inputs();
    h_we_i           = 1'b0;
    h_addr_i         = '0;
    h_data_i         = '0;
    info_we_i        = 1'b0;
    info_addr_i      = '0;
    info_data_i      = '0;
    wgt_we_i         = 1'b0;
    wgt_addr_i       = '0;
    wgt_data_i       = '0;
    h_load_done_i    = 1'b0;
    info_load_done_i = 1'b0;
    wgt_load_done_i  = 1'b0;
    feat_addr_i      = '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b0;
    idle_inputs();
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
  endtask

  task automatic build_graph(input int mode);
    int n;
    int k;
    int i;
    int len;
    h_used = 0;
    for (n = 0; n < NUM_NODES; n++) begin
      case (mode)
        GRAPH_IDENTITY: len = 4 + (n % 5);
        GRAPH_ZEROS:    len = (n % 3 == 0) ? 0 : 1 + int'(next_rand() % 6);
        default:        len = int'(next_rand() % 17);
      endcase
      // Rows share one H memory
      if (h_used + len > H_DEPTH) begin
        len = H_DEPTH - h_used;
      end
      row_len[n] = len;
      for (k = 0; k < len; k++) begin
        if (mode == GRAPH_IDENTITY) begin
          h_col[h_used] = COL_IDX_WIDTH'(k);
          h_val[h_used] = byte'((n * 7 + k * 3 + 1) % 101 - 50);
        end else begin
          h_col[h_used] = COL_IDX_WIDTH'(next_rand() % FEAT_IN);
          h_val[h_used] = byte'(next_rand());
        end
        h_used++;
      end
    end
    for (i = 0; i < FEAT_IN; i++) begin
      for (k = 0; k < FEAT_OUT; k++) begin
        if (mode == GRAPH_IDENTITY) begin
          w_mat[i][k] = (i == k) ? 8'sd1 : 8'sd0;
        end else begin
          w_mat[i][k] = byte'(next_rand());
        end
      end
    end
    for (k = 0; k < FEAT_OUT; k++) begin
      a_vec[k] = (mode == GRAPH_IDENTITY) ? 8'sd1 : byte'(next_rand());
    end
  endtask

  task automatic compute_expected();
    int n;
    int k;
    int o;
    int p;
    p = 0;
    for (n = 0; n < NUM_NODES; n++) begin
      for (o = 0; o < FEAT_OUT; o++) begin
        exp_wh[n][o] = 0;
      end
      for (k = 0; k < row_len[n]; k++) begin
        for (o = 0; o < FEAT_OUT; o++) begin
          exp_wh[n][o] += int'(h_val[p]) * int'(w_mat[h_col[p]][o]);
        end
        p++;
      end
      exp_score[n] = 0;
      for (o = 0; o < FEAT_OUT; o++) begin
        exp_score[n] += int'(a_vec[o]) * exp_wh[n][o];
      end
    end
  endtask

  task automatic load_memories();
    int i;
    for (i = 0; i < h_used; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      h_we_i         = 1'b1;
      h_addr_i       = H_AW'(i);
      h_data_i.value = h_val[i];
      h_data_i.col   = h_col[i];
    end
    @(posedge clk);
    #DRIVE_DLY;
    h_we_i = 1'b0;
    for (i = 0; i < NUM_NODES; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      info_we_i           = 1'b1;
      info_addr_i         = NODE_W'(i);
      info_data_i.row_len = ROW_LEN_WIDTH'(row_len[i]);
    end
    @(posedge clk);
    #DRIVE_DLY;
    info_we_i = 1'b0;
    // W row by row, then a
    for (i = 0; i < WGT_DEPTH; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      wgt_we_i   = 1'b1;
      wgt_addr_i = WGT_AW'(i);
      if (i < FEAT_IN * FEAT_OUT) begin
        wgt_data_i = w_mat[i / FEAT_OUT][i % FEAT_OUT];
      end else begin
        wgt_data_i = a_vec[i - FEAT_IN * FEAT_OUT];
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    wgt_we_i = 1'b0;
  endtask

  task automatic set_done_levels(input logic h, input logic info, input logic wgt);
    @(posedge clk);
    #DRIVE_DLY;
    h_load_done_i    = h;
    info_load_done_i = info;
    wgt_load_done_i  = wgt;
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    while (done_o !== 1'b1 && n < DONE_WAIT) begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    checks++;
    if (done_o !== 1'b1) begin
      errors++;
      $display("Error at %0t: done_o never rose within %0d cycles in %s", $time, DONE_WAIT,
               what);
    end
  endtask

  task automatic read_feat(input int n, output feat_word_t word);
    @(posedge clk);
    #DRIVE_DLY;
    feat_addr_i = NODE_W'(n);
    @(posedge clk);
    #DRIVE_DLY;
    word = feat_dout_o;
  endtask

  task automatic check_all_nodes(input string what);
    feat_word_t         word;
    int                 n;
    int                 o;
    logic signed [31:0] got;
    for (n = 0; n < NUM_NODES; n++) begin
      read_feat(n, word);
      for (o = 0; o < FEAT_OUT; o++) begin
        checks++;
        got = $signed(word.wh[o]);
        if (got !== exp_wh[n][o]) begin
          errors++;
          $display("[FAIL] %0t: %s node %0d lane %0d WH is %0d, expected %0d", $time, what,
                   n, o, got, exp_wh[n][o]);
        end
      end
      checks++;
      got = word.score;
      if (got !== exp_score[n]) begin
        errors++;
        $display("[FAIL] %0t: %s node %0d score is %0d, expected %0d", $time, what, n, got,
                 exp_score[n]);
      end
    end
  endtask

  task automatic run_graph(input int mode, input string what);
    apply_reset();
    build_graph(mode);
    compute_expected();
    load_memories();
    set_done_levels(1'b1, 1'b1, 1'b1);
    wait_done(what);
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_idle_after_reset();
    int   i;
    logic seen;
    apply_reset();
    seen = 1'b0;
    checks++;
    for (i = 0; i < 50; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (done_o !== 1'b0 && !seen) begin
        seen = 1'b1;
        errors++;
        $display("[FAIL] %0t: done_o went high with no memory loaded", $time);
      end
    end
  endtask

  task automatic test_waits_for_info();
    int   i;
    logic seen;
    apply_reset();
    build_graph(GRAPH_RANDOM);
    compute_expected();
    load_memories();
    set_done_levels(1'b1, 1'b0, 1'b1);
    seen = 1'b0;
    checks++;
    for (i = 0; i < 200; i++) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (done_o !== 1'b0 && !seen) begin
        seen = 1'b1;
        errors++;
        $display("[FAIL] %0t: done_o rose while info_load_done_i was low", $time);
      end
    end
    set_done_levels(1'b1, 1'b1, 1'b1);
    wait_done("info gate test");
    check_all_nodes("info gate");
  endtask

  task automatic test_read_latency();
    feat_word_t word;
    run_graph(GRAPH_IDENTITY, "latency test");
    read_feat(3, word);
    checks++;
    if (word !== expected_word(3)) begin
      errors++;
      $display("[FAIL] %0t: node 3 word wrong one cycle after its address", $time);
    end
    @(posedge clk);
    #DRIVE_DLY;
    feat_addr_i = NODE_W'(9);
    checks++;
    if (feat_dout_o !== expected_word(3)) begin
      errors++;
      $display("[FAIL] %0t: read data changed in the same cycle as the address", $time);
    end
    @(posedge clk);
    #DRIVE_DLY;
    checks++;
    if (feat_dout_o !== expected_word(9)) begin
      errors++;
      $display("[FAIL] %0t: node 9 word not shown one cycle after its address", $time);
    end
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    rng_state = 32'd81;
    clk       = 1'b0;
    rst_n     = 1'b0;
    idle_inputs();

    test_idle_after_reset();
    test_waits_for_info();
    run_graph(GRAPH_IDENTITY, "identity test");
    check_all_nodes("identity");
    run_graph(GRAPH_RANDOM, "random test");
    check_all_nodes("random");
    // Empty rows every third node
    run_graph(GRAPH_ZEROS, "empty row test");
    check_all_nodes("empty rows");
    test_read_latency();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* all.f */
design/gat_pkg.sv
design/gat_bram.sv
design/weight_scheduler.sv
design/sparse_wh_engine.sv
design/attention_score.sv
design/gat_core.sv
tb/tb_gat_core.sv

/* Bender.yml */
package:
  name: gat_core

sources:
  - design/gat_pkg.sv
  - design/gat_bram.sv
  - design/weight_scheduler.sv
  - design/sparse_wh_engine.sv
  - design/attention_score.sv
  - design/gat_core.sv
  - target: test
    files:
      - tb/tb_gat_core.sv
